// ==== hdl/gw_channel_tunnel.sv ====
module gw_channel_tunnel
  import gw_link_pkg::*;
( input                                 core_clk_i
, input                                 rst_n_i

, input  [CT_NUM_IN-1:0]                ch_in_v_i
, input  [CT_NUM_IN-1:0][CT_WIDTH-1:0]  ch_in_data_i
, output [CT_NUM_IN-1:0]                ch_in_yumi_o

, output                                multi_v_o
, output [LINK_WIDTH-1:0]               multi_data_o
, input                                 multi_ready_i

, input                                 multi_v_i
, input  [LINK_WIDTH-1:0]               multi_data_i
, output                                multi_yumi_o

, output [CT_NUM_IN-1:0]                ch_v_o
, output [CT_NUM_IN-1:0][CT_WIDTH-1:0]  ch_data_o
, input  [CT_NUM_IN-1:0]                ch_ready_i
);

  logic [CT_NUM_IN-1:0][CT_CNT_WIDTH-1:0] credit_r;  // Remote buffer space per channel
  logic [CT_NUM_IN-1:0][CT_CNT_WIDTH-1:0] freed_r;   // Local pops not yet reported
  logic [CT_ID_WIDTH-1:0]                 last_r;

  logic [CT_NUM_IN-1:0] eligible;
  logic [CT_NUM_IN-1:0] rx_v;
  logic [CT_NUM_IN-1:0] rx_buf_ready;
  logic [CT_NUM_IN-1:0] rx_pop;
  logic [CT_ID_WIDTH-1:0] grant_id;
  logic [CT_ID_WIDTH-1:0] rx_id;
  logic [CT_WIDTH-1:0]  credit_payload;
  logic grant_found;
  logic credit_pending;
  logic send;
  logic rx_credit;
  logic rx_ready;
  logic rx_take;
  ct_sel_e sel;

  // ########################################
  // Transmit
  // ########################################

  for (genvar i = 0; i < CT_NUM_IN; i++)
  begin : elig
    assign eligible[i]     = ch_in_v_i[i] && (credit_r[i] != '0);
    assign ch_in_yumi_o[i] = send && (sel == SEL_DATA) && (grant_id == CT_ID_WIDTH'(i));
  end

  // Round robin starting after the channel served last
  always_comb
  begin
    int idx;
    grant_found = 1'b0;
    grant_id    = '0;
    for (int k = 1; k <= CT_NUM_IN; k++)
    begin
      idx = (int'(last_r) + k) % CT_NUM_IN;
      if (!grant_found && eligible[idx])
      begin
        grant_found = 1'b1;
        grant_id    = CT_ID_WIDTH'(idx);
      end
    end
  end

  always_comb
  begin
    credit_payload = '0;
    credit_pending = 1'b0;
    for (int i = 0; i < CT_NUM_IN; i++)
    begin
      credit_payload[i*CT_CNT_WIDTH +: CT_CNT_WIDTH] = freed_r[i];
      credit_pending = credit_pending | (freed_r[i] != '0);
    end
  end

  always_comb
  begin
    sel = SEL_NONE;
    if (credit_pending)
      sel = SEL_CREDIT;  // Credits go ahead of data
    else if (grant_found)
      sel = SEL_DATA;
  end

  assign multi_v_o    = (sel != SEL_NONE);
  assign multi_data_o = (sel == SEL_CREDIT) ? {CT_ID_WIDTH'(CT_CREDIT_ID), credit_payload}
                                            : {grant_id, ch_in_data_i[grant_id]};
  assign send         = multi_v_o & multi_ready_i;

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      last_r   <= CT_ID_WIDTH'(CT_NUM_IN - 1);
      credit_r <= {CT_NUM_IN{CT_CNT_WIDTH'(CT_REMOTE_CREDITS)}};
      freed_r  <= '0;
    end
    else
    begin
      if (send && (sel == SEL_DATA))
        last_r <= grant_id;
      for (int i = 0; i < CT_NUM_IN; i++)
      begin
        credit_r[i] <= credit_r[i] - CT_CNT_WIDTH'(ch_in_yumi_o[i])
                     + ((rx_take && rx_credit) ? multi_data_i[i*CT_CNT_WIDTH +: CT_CNT_WIDTH]
                                               : '0);
        if (send && (sel == SEL_CREDIT))
          freed_r[i] <= CT_CNT_WIDTH'(rx_pop[i]);  // Whole count went out this cycle
        else
          freed_r[i] <= freed_r[i] + CT_CNT_WIDTH'(rx_pop[i]);
      end
    end
  end

  // ########################################
  // Receive
  // ########################################

  assign rx_id     = multi_data_i[LINK_WIDTH-1 -: CT_ID_WIDTH];
  assign rx_credit = (rx_id == CT_ID_WIDTH'(CT_CREDIT_ID));

  always_comb
  begin
    rx_ready = rx_credit;
    for (int i = 0; i < CT_NUM_IN; i++)
      if (rx_id == CT_ID_WIDTH'(i))
        rx_ready = rx_buf_ready[i];
  end

  assign rx_take      = multi_v_i & rx_ready;
  assign multi_yumi_o = rx_take;
  assign rx_pop       = ch_v_o & ch_ready_i;

  for (genvar i = 0; i < CT_NUM_IN; i++)
  begin : rx
    logic                mid_v;
    logic [CT_WIDTH-1:0] mid_data;
    logic                mid_ready;

    assign rx_v[i] = multi_v_i & ~rx_credit & (rx_id == CT_ID_WIDTH'(i));

    // Two chained entries give the buffer depth matching the remote credits
    gw_two_fifo rx_head
      (.core_clk_i ( core_clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.v_i        ( rx_v[i] )
      ,.data_i     ( multi_data_i[CT_WIDTH-1:0] )
      ,.ready_o    ( rx_buf_ready[i] )
      ,.v_o        ( mid_v )
      ,.data_o     ( mid_data )
      ,.yumi_i     ( mid_v & mid_ready )
      );

    gw_two_fifo rx_tail
      (.core_clk_i ( core_clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.v_i        ( mid_v )
      ,.data_i     ( mid_data )
      ,.ready_o    ( mid_ready )
      ,.v_o        ( ch_v_o[i] )
      ,.data_o     ( ch_data_o[i] )
      ,.yumi_i     ( rx_pop[i] )
      );
  end

  // The far tunnel spends credits so a data word always finds room
  a_rx_has_room: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    (multi_v_i && !rx_credit) |-> rx_ready)
    else $error("data word arrived for a full receive buffer");

endmodule

// ==== hdl/gw_link_ct_top.sv ====
module gw_link_ct_top
  import gw_link_pkg::*;
( input                                 core_clk_i
, input                                 rst_n_i

, input  [CT_NUM_IN-1:0]                ch_v_i
, input  [CT_NUM_IN-1:0][CT_WIDTH-1:0]  ch_data_i
, output [CT_NUM_IN-1:0]                ch_ready_o

, output [CT_NUM_IN-1:0]                ch_v_o
, output [CT_NUM_IN-1:0][CT_WIDTH-1:0]  ch_data_o
, input  [CT_NUM_IN-1:0]                ch_ready_i

, output                                link_v_o
, output [LINK_CHANNEL_WIDTH-1:0]       link_data_o
, input                                 link_tkn_i

, input                                 link_v_i
, input  [LINK_CHANNEL_WIDTH-1:0]       link_data_i
, output                                link_tkn_o
);

  logic [CT_NUM_IN-1:0]                 fifo_v_lo;
  logic [CT_NUM_IN-1:0][CT_WIDTH-1:0]   fifo_data_lo;
  logic [CT_NUM_IN-1:0]                 fifo_yumi_li;

  logic                  multi_v_lo;
  logic [LINK_WIDTH-1:0] multi_data_lo;
  logic                  up_ready_lo;

  logic                  down_v_lo;
  logic [LINK_WIDTH-1:0] down_data_lo;
  logic                  down_yumi_li;

  // ########################################
  // Channel entry FIFOs
  // ########################################

  for (genvar i = 0; i < CT_NUM_IN; i++)
  begin : entry
    gw_two_fifo entry_fifo
      (.core_clk_i ( core_clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.v_i        ( ch_v_i[i] )
      ,.data_i     ( ch_data_i[i] )
      ,.ready_o    ( ch_ready_o[i] )
      ,.v_o        ( fifo_v_lo[i] )
      ,.data_o     ( fifo_data_lo[i] )
      ,.yumi_i     ( fifo_yumi_li[i] )
      );
  end

  gw_channel_tunnel tunnel
    (.core_clk_i    ( core_clk_i )
    ,.rst_n_i       ( rst_n_i )
    ,.ch_in_v_i     ( fifo_v_lo )
    ,.ch_in_data_i  ( fifo_data_lo )
    ,.ch_in_yumi_o  ( fifo_yumi_li )
    ,.multi_v_o     ( multi_v_lo )
    ,.multi_data_o  ( multi_data_lo )
    ,.multi_ready_i ( up_ready_lo )
    ,.multi_v_i     ( down_v_lo )
    ,.multi_data_i  ( down_data_lo )
    ,.multi_yumi_o  ( down_yumi_li )
    ,.ch_v_o        ( ch_v_o )
    ,.ch_data_o     ( ch_data_o )
    ,.ch_ready_i    ( ch_ready_i )
    );

  // ########################################
  // Link directions
  // ########################################

  gw_link_upstream uplink
    (.core_clk_i   ( core_clk_i )
    ,.rst_n_i      ( rst_n_i )
    ,.core_data_i  ( multi_data_lo )
    ,.core_valid_i ( multi_v_lo )
    ,.core_ready_o ( up_ready_lo )
    ,.link_v_o     ( link_v_o )
    ,.link_data_o  ( link_data_o )
    ,.link_tkn_i   ( link_tkn_i )
    );

  gw_link_downstream downlink
    (.core_clk_i   ( core_clk_i )
    ,.rst_n_i      ( rst_n_i )
    ,.link_v_i     ( link_v_i )
    ,.link_data_i  ( link_data_i )
    ,.link_tkn_o   ( link_tkn_o )
    ,.core_data_o  ( down_data_lo )
    ,.core_valid_o ( down_v_lo )
    ,.core_yumi_i  ( down_yumi_li )
    );

endmodule

// ==== hdl/gw_link_downstream.sv ====
module gw_link_downstream
  import gw_link_pkg::*;
( input                           core_clk_i
, input                           rst_n_i

, input                           link_v_i
, input  [LINK_CHANNEL_WIDTH-1:0] link_data_i
, output                          link_tkn_o

, output [LINK_WIDTH-1:0]         core_data_o
, output                          core_valid_o
, input                           core_yumi_i
);

  logic [LINK_BEAT_CNT_WIDTH-1:0]               beat_cnt_r;
  logic [LINK_WIDTH-LINK_CHANNEL_WIDTH-1:0]     asm_r;  // Beats received so far
  logic [LINK_WIDTH-1:0]                        mem_r [LINK_FIFO_DEPTH];
  logic [LINK_PTR_WIDTH-1:0]                    wptr_r;
  logic [LINK_PTR_WIDTH-1:0]                    rptr_r;
  logic                                         tkn_r;

  logic wr_en;
  logic empty;
  logic full;

  assign wr_en = link_v_i && (beat_cnt_r == LINK_BEAT_CNT_WIDTH'(LINK_BEATS - 1));
  assign empty = (wptr_r == rptr_r);
  assign full  = (wptr_r == {~rptr_r[LINK_PTR_WIDTH-1], rptr_r[LINK_LG_FIFO_DEPTH-1:0]});

  // ########################################
  // Beat assembly
  // ########################################

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
      beat_cnt_r <= '0;
    else if (wr_en)
      beat_cnt_r <= '0;
    else if (link_v_i)
      beat_cnt_r <= beat_cnt_r + 1'b1;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (link_v_i)
      asm_r <= {link_data_i, asm_r[LINK_WIDTH-LINK_CHANNEL_WIDTH-1:LINK_CHANNEL_WIDTH]};
  end

  // ########################################
  // Word FIFO and token return
  // ########################################

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
      tkn_r  <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wptr_r <= wptr_r + 1'b1;
      if (core_yumi_i)
        rptr_r <= rptr_r + 1'b1;
      tkn_r <= core_yumi_i;  // One token per word taken by the core
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (wr_en)
      mem_r[wptr_r[LINK_LG_FIFO_DEPTH-1:0]] <= {link_data_i, asm_r};
  end

  assign core_valid_o = ~empty;
  assign core_data_o  = mem_r[rptr_r[LINK_LG_FIFO_DEPTH-1:0]];
  assign link_tkn_o   = tkn_r;

  // A word arriving into a full FIFO means the sender ignored its tokens
  a_no_overflow: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    wr_en |-> !full)
    else $error("downstream word FIFO written while full");

endmodule

// ==== hdl/gw_link_pkg.sv ====
package gw_link_pkg;

  // ########################################
  // Channel tunnel
  // ########################################

  localparam int CT_NUM_IN         = 3;
  localparam int CT_WIDTH          = 16;
  localparam int CT_ID_WIDTH       = 2;
  localparam int CT_REMOTE_CREDITS = 4;
  localparam int CT_CREDIT_ID      = 3;  // Id value that marks a credit word

  // One count field per channel inside a credit word payload
  localparam int CT_CNT_WIDTH = 4;

  // ########################################
  // Link
  // ########################################

  localparam int LINK_WIDTH          = CT_WIDTH + CT_ID_WIDTH;
  localparam int LINK_CHANNEL_WIDTH  = 6;
  localparam int LINK_BEATS          = LINK_WIDTH / LINK_CHANNEL_WIDTH;
  localparam int LINK_BEAT_CNT_WIDTH = $clog2(LINK_BEATS);
  localparam int LINK_LG_FIFO_DEPTH  = 2;
  localparam int LINK_FIFO_DEPTH     = 1 << LINK_LG_FIFO_DEPTH;

  // Pointers and token counts carry one extra bit to tell full from empty
  localparam int LINK_PTR_WIDTH = LINK_LG_FIFO_DEPTH + 1;

  typedef enum logic
  {
    LINK_IDLE,
    LINK_SEND
  } link_state_e;

  typedef enum logic [1:0]
  {
    SEL_NONE,
    SEL_DATA,
    SEL_CREDIT
  } ct_sel_e;

endpackage

// ==== hdl/gw_link_upstream.sv ====
module gw_link_upstream
  import gw_link_pkg::*;
( input                           core_clk_i
, input                           rst_n_i

, input  [LINK_WIDTH-1:0]         core_data_i
, input                           core_valid_i
, output                          core_ready_o

, output                          link_v_o
, output [LINK_CHANNEL_WIDTH-1:0] link_data_o
, input                           link_tkn_i
);

  link_state_e state_r;

  logic [LINK_BEAT_CNT_WIDTH-1:0] beat_cnt_r;
  logic [LINK_WIDTH-1:0]          shift_r;
  logic [LINK_PTR_WIDTH-1:0]      tkn_cnt_r;

  logic last_beat;
  logic accept;

  assign last_beat = (state_r == LINK_SEND) &&
                     (beat_cnt_r == LINK_BEAT_CNT_WIDTH'(LINK_BEATS - 1));

  // A new word may follow the last beat without a gap
  assign core_ready_o = (tkn_cnt_r != '0) && ((state_r == LINK_IDLE) || last_beat);
  assign accept       = core_valid_i & core_ready_o;

  // ########################################
  // Serializer
  // ########################################

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r    <= LINK_IDLE;
      beat_cnt_r <= '0;
    end
    else
    begin
      if (accept)
      begin
        state_r    <= LINK_SEND;
        beat_cnt_r <= '0;
      end
      else if (last_beat)
      begin
        state_r    <= LINK_IDLE;
        beat_cnt_r <= '0;
      end
      else if (state_r == LINK_SEND)
        beat_cnt_r <= beat_cnt_r + 1'b1;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (accept)
      shift_r <= core_data_i;
    else if (state_r == LINK_SEND)
      shift_r <= shift_r >> LINK_CHANNEL_WIDTH;  // Low slice goes out first
  end

  assign link_v_o    = (state_r == LINK_SEND);
  assign link_data_o = shift_r[LINK_CHANNEL_WIDTH-1:0];

  // ########################################
  // Token credit
  // ########################################

  // Each word spends one slot of the far word FIFO
  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
      tkn_cnt_r <= LINK_PTR_WIDTH'(LINK_FIFO_DEPTH);
    else
      tkn_cnt_r <= tkn_cnt_r + LINK_PTR_WIDTH'(link_tkn_i) - LINK_PTR_WIDTH'(accept);
  end

  // More tokens than far FIFO slots means the far side returned extra pulses
  a_tkn_in_range: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    tkn_cnt_r <= LINK_PTR_WIDTH'(LINK_FIFO_DEPTH))
    else $error("upstream token count above FIFO depth");

endmodule

// ==== hdl/gw_two_fifo.sv ====
module gw_two_fifo
  import gw_link_pkg::*;
( input                 core_clk_i
, input                 rst_n_i

, input                 v_i
, input  [CT_WIDTH-1:0] data_i
, output                ready_o

, output                v_o
, output [CT_WIDTH-1:0] data_o
, input                 yumi_i
);

  logic [CT_WIDTH-1:0] mem_r [2];

  logic wptr_r;
  logic rptr_r;
  logic empty_r;
  logic ready_r;  // Registered inverse of full, held low during reset

  logic enq;
  logic full_now;
  logic full_next;

  assign enq      = v_i & ready_r;
  assign full_now = ~empty_r & (wptr_r == rptr_r);

  always_comb
  begin
    full_next = full_now;
    if (enq & ~yumi_i)
      full_next = (~wptr_r == rptr_r);
    else if (yumi_i & ~enq)
      full_next = 1'b0;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      empty_r <= 1'b1;
      ready_r <= 1'b0;
    end
    else
    begin
      ready_r <= ~full_next;
      if (enq)
        wptr_r <= ~wptr_r;
      if (yumi_i)
        rptr_r <= ~rptr_r;
      if (enq != yumi_i)
        empty_r <= yumi_i & (~rptr_r == wptr_r);  // Last entry leaves
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

  assign ready_o = ready_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rptr_r];

  // The consumer may only take an entry that is on offer
  a_yumi_needs_valid: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o)
    else $error("two fifo popped while empty");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the loopback testbench with Verilator, run it and scan the log for the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_gw_link_ct \
  -f sources.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_gw_link_ct > sim.log 2>&1
cat sim.log

grep -qx '\*\* PASS \*\*' sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
hdl/gw_link_pkg.sv
hdl/gw_two_fifo.sv
hdl/gw_link_upstream.sv
hdl/gw_link_downstream.sv
hdl/gw_channel_tunnel.sv
hdl/gw_link_ct_top.sv
verification/tb_gw_link_ct.sv

// ==== verification/tb_gw_link_ct.sv ====
module tb_gw_link_ct
  import gw_link_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WORDS_PER_CH    = 300;
  localparam int CYCLES_PER_WORD = 40;
  localparam int TIMEOUT_CYCLES  = WORDS_PER_CH * CT_NUM_IN * CYCLES_PER_WORD;
  localparam int STALL_START     = 300;  // Channel 0 output is held off in this window
  localparam int STALL_CYCLES    = 400;
  localparam int QUIET_CYCLES    = 10;

  logic                               core_clk;
  logic                               rst_n;
  logic [CT_NUM_IN-1:0]               ch_v_i;
  logic [CT_NUM_IN-1:0][CT_WIDTH-1:0] ch_data_i;
  logic [CT_NUM_IN-1:0]               ch_ready_o;
  logic [CT_NUM_IN-1:0]               ch_v_o;
  logic [CT_NUM_IN-1:0][CT_WIDTH-1:0] ch_data_o;
  logic [CT_NUM_IN-1:0]               ch_ready_i;
  logic                               link_v;
  logic [LINK_CHANNEL_WIDTH-1:0]      link_data;
  logic                               link_tkn;

  logic [CT_WIDTH-1:0]  model_q [CT_NUM_IN][$];
  int                   sent_cnt [CT_NUM_IN];
  int                   recv_cnt [CT_NUM_IN];
  logic [CT_NUM_IN-1:0] accepted;
  integer               seed;
  int error_cnt;
  int cycle_cnt;
  int run_len;
  int beat_cnt;
  int link_words;
  int tkn_cnt;
  int quiet_cnt;
  int stall_pops;
  logic timed_out;

  // The chip's link output is looped back to its own link input
  gw_link_ct_top gw_link_ct_top_inst
    (.core_clk_i  ( core_clk )
    ,.rst_n_i     ( rst_n )
    ,.ch_v_i      ( ch_v_i )
    ,.ch_data_i   ( ch_data_i )
    ,.ch_ready_o  ( ch_ready_o )
    ,.ch_v_o      ( ch_v_o )
    ,.ch_data_o   ( ch_data_o )
    ,.ch_ready_i  ( ch_ready_i )
    ,.link_v_o    ( link_v )
    ,.link_data_o ( link_data )
    ,.link_tkn_i  ( link_tkn )
    ,.link_v_i    ( link_v )
    ,.link_data_i ( link_data )
    ,.link_tkn_o  ( link_tkn )
    );

  initial
  begin
    core_clk = 1'b0;
    forever #10 core_clk = ~core_clk;
  end

  // ########################################
  // Checks and model
  // ########################################

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected)
    begin
      $display("** Error at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
      error_cnt++;
    end
  endtask

  task automatic drive_channels(input logic stall);
    for (int c = 0; c < CT_NUM_IN; c++)
    begin
      if (!(ch_v_i[c] && !accepted[c]))  // A word on offer stays until it is taken
      begin
        ch_v_i[c]    = (sent_cnt[c] < WORDS_PER_CH) && (($unsigned($random(seed)) % 4) != 0);
        ch_data_i[c] = CT_WIDTH'($random(seed));
      end
      ch_ready_i[c] = (($unsigned($random(seed)) % 10) >= 3);
    end
    if (stall)
      ch_ready_i[0] = 1'b0;
  endtask

  task automatic record_transfers(input logic stall);
    logic [CT_WIDTH-1:0] expected;
    for (int c = 0; c < CT_NUM_IN; c++)
    begin
      accepted[c] = ch_v_i[c] & ch_ready_o[c];
      if (accepted[c])
      begin
        model_q[c].push_back(ch_data_i[c]);
        sent_cnt[c]++;
      end
      if (ch_v_o[c] && ch_ready_i[c])
      begin
        if (model_q[c].size() == 0)
        begin
          $display("Channel %0d delivered a word that was never sent, time %0t", c, $time);
          error_cnt++;
        end
        else
        begin
          expected = model_q[c].pop_front();
          check_equal(32'(ch_data_o[c]), 32'(expected),
                      $sformatf("channel %0d word %0d data", c, recv_cnt[c]));
        end
        recv_cnt[c]++;
        if (stall && (c != 0))
          stall_pops++;
      end
      // Entry FIFO plus the remote credits bound the words inside the chip
      check_equal(32'(model_q[c].size() <= CT_REMOTE_CREDITS + 2), 32'd1,
                  $sformatf("channel %0d words in flight above limit", c));
    end
  endtask

  task automatic watch_link();
    if (link_v)
    begin
      run_len++;
      beat_cnt++;
      if (beat_cnt == LINK_BEATS)
      begin
        link_words++;
        beat_cnt = 0;
      end
    end
    else if (run_len != 0)
    begin
      check_equal(32'(run_len % LINK_BEATS), 32'd0, "link burst not a whole number of words");
      run_len = 0;
    end
    if (link_tkn)
      tkn_cnt++;
    check_equal(32'(link_words - tkn_cnt <= LINK_FIFO_DEPTH), 32'd1,
                "link words without token above FIFO depth");
    quiet_cnt = (link_v || link_tkn) ? 0 : quiet_cnt + 1;
  endtask

  function automatic logic traffic_done();
    logic done;
    done = (link_words == tkn_cnt) && (quiet_cnt >= QUIET_CYCLES);
    for (int c = 0; c < CT_NUM_IN; c++)
      done = done && (sent_cnt[c] == WORDS_PER_CH) && (model_q[c].size() == 0);
    return done;
  endfunction

  // ########################################
  // Main sequence
  // ########################################

  initial
  begin
    logic stall;
    int   total_sent;
    int   total_recv;
    seed           = 32'h90b8;
    error_cnt      = 0;
    cycle_cnt      = 0;
    run_len        = 0;
    beat_cnt       = 0;
    link_words     = 0;
    tkn_cnt        = 0;
    quiet_cnt      = 0;
    stall_pops     = 0;
    timed_out      = 1'b0;
    total_sent     = 0;
    total_recv     = 0;
    rst_n      = 1'b0;
    ch_v_i     = '0;
    ch_data_i  = '0;
    ch_ready_i = '0;
    accepted   = '0;
    for (int c = 0; c < CT_NUM_IN; c++)
    begin
      sent_cnt[c] = 0;
      recv_cnt[c] = 0;
    end

    repeat (4) @(negedge core_clk);
    check_equal(32'(ch_v_o), 32'd0, "ch_v_o in reset");
    check_equal(32'(ch_ready_o), 32'd0, "ch_ready_o in reset");
    check_equal(32'(link_v), 32'd0, "link_v_o in reset");
    check_equal(32'(link_tkn), 32'd0, "link_tkn_o in reset");
    rst_n = 1'b1;

    // No traffic yet, so nothing may come out
    repeat (5)
    begin
      @(negedge core_clk);
      check_equal(32'(ch_v_o), 32'd0, "ch_v_o before first input");
      check_equal(32'(link_v), 32'd0, "link_v_o before first input");
      check_equal(32'(link_tkn), 32'd0, "link_tkn_o before first input");
    end

    while (!traffic_done() && !timed_out)
    begin
      @(negedge core_clk);
      cycle_cnt++;
      stall = (cycle_cnt >= STALL_START) && (cycle_cnt < STALL_START + STALL_CYCLES);
      drive_channels(stall);
      record_transfers(stall);
      watch_link();
      if (cycle_cnt == STALL_START + STALL_CYCLES - 1)
      begin
        // A stalled channel holds its two entry words plus one word per remote credit
        check_equal(32'(ch_ready_o[0]), 32'd0, "channel 0 entry not full after the stall");
        check_equal(32'(model_q[0].size()), 32'(CT_REMOTE_CREDITS + 2),
                    "channel 0 words held after the stall");
        check_equal(32'(stall_pops > 0), 32'd1, "other channels stopped during the stall");
      end
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
        $display("Timeout: traffic did not finish within %0d cycles", TIMEOUT_CYCLES);
        timed_out = 1'b1;
      end
    end

    for (int c = 0; c < CT_NUM_IN; c++)
    begin
      check_equal(32'(model_q[c].size()), 32'd0, $sformatf("channel %0d words lost", c));
      check_equal(32'(recv_cnt[c]), 32'(WORDS_PER_CH), $sformatf("channel %0d word count", c));
      total_sent += sent_cnt[c];
      total_recv += recv_cnt[c];
    end
    $display("Sent %0d words, received %0d, link words %0d, tokens %0d, errors %0d",
             total_sent, total_recv, link_words, tkn_cnt, error_cnt);
    if ((error_cnt == 0) && !timed_out)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
